// File: sources.f
hw/rv32i_types.sv
hw/ctrl_types.sv
hw/ctrl_word.sv
hw/stage_reg.sv
hw/hazard_unit.sv
hw/ctrl_pipeline.sv
dv/ctrl_pipeline_checker.sv
dv/ctrl_pipeline_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the control pipeline simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ctrl_pipeline_tb \
    -f sources.f -o sim > build.log 2>&1 &&
./obj_dir/sim > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"

// File: dv/ctrl_pipeline_tb.sv
`timescale 1ns/1ns

module ctrl_pipeline_tb
    import rv32i_types::*;
    import ctrl_types::*;
;

    logic         clk;
    logic         reset;
    logic [31:0]  instr;
    logic         instr_valid;
    logic         branch_taken;
    logic         stall;
    logic         imem_read;
    logic         ex_valid;
    ctrlex_reg_t  ctrlex;
    logic         mem_valid;
    ctrlmem_reg_t ctrlmem;
    logic         dmem_read;
    logic         dmem_write;
    logic         wb_valid;
    ctrlwb_reg_t  ctrlwb;

    logic [31:0]  lfsr = 32'd90892;
    string        cur_test = "reset_state";
    int           errors = 0;
    int           checks = 0;
    int           tests = 0;
    ex_stage_t    shadow [3];                  // Expected words in EX, MEM, WB.
    logic [2:0]   vld = '0;
    logic         exp_stall;

    ctrl_pipeline i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ########################################
    // Stimulus helpers
    // ########################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[6:0], lfsr[0]};             // One step per bit.
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic logic [31:0] encode(input rv32i_opcode op, input logic [2:0] f3,
                                           input logic b5, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {1'b0, b5, 5'b0, rs2, rs1, f3, rd, 7'(op)};
    endfunction

    // ########################################
    // Reference model
    // ########################################

    function automatic logic reads_rs1(input logic [6:0] op);
        return op inside {op_jalr, op_load, op_imm, op_br, op_store, op_reg};
    endfunction

    function automatic logic reads_rs2(input logic [6:0] op);
        return op inside {op_br, op_store, op_reg};
    endfunction

    function automatic ex_stage_t model_decode(input logic [31:0] w);
        ex_stage_t e;
        logic [2:0] f3;
        logic b5;
        f3 = w[14:12];
        b5 = w[30];
        e = '0;
        e.ex.cmpop = branch_funct3_t'(f3);
        e.mem.funct3 = f3;
        e.wb.rd = w[11:7];
        e.wb.rs1 = w[19:15];
        e.wb.rs2 = w[24:20];
        case (w[6:0])
            op_lui: begin
                e.wb.load_regfile = 1'b1;
                e.wb.regfilemux_sel = regfilemux_u_imm;
            end
            op_auipc: begin
                e.ex.alumux1_sel = alumux1_pc_out;
                e.ex.alumux2_sel = alumux2_u_imm;
                e.wb.load_regfile = 1'b1;
            end
            op_jal, op_jalr: begin
                e.ex.pcmux_sel = (w[6:0] == op_jal) ? pcmux_alu_out : pcmux_alu_mod2;
                e.ex.alumux1_sel = (w[6:0] == op_jal) ? alumux1_pc_out : alumux1_rs1_out;
                e.ex.alumux2_sel = (w[6:0] == op_jal) ? alumux2_j_imm : alumux2_i_imm;
                e.wb.load_regfile = 1'b1;
                e.wb.regfilemux_sel = regfilemux_pc_plus4;
            end
            op_br: begin
                e.ex.alumux1_sel = alumux1_pc_out;
                e.ex.alumux2_sel = alumux2_b_imm;
                e.ex.is_branch = 1'b1;
            end
            op_load: begin
                e.mem.marmux_sel = marmux_alu_out;
                e.mem.dmem_read = 1'b1;
                e.wb.load_regfile = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
                case (f3)
                    3'd0: e.wb.regfilemux_sel = regfilemux_lb;
                    3'd1: e.wb.regfilemux_sel = regfilemux_lh;
                    3'd2: e.wb.regfilemux_sel = regfilemux_lw;
                    3'd4: e.wb.regfilemux_sel = regfilemux_lbu;
                    3'd5: e.wb.regfilemux_sel = regfilemux_lhu;
                    default: e.wb.regfilemux_sel = regfilemux_alu_out;
                endcase
            end
            op_store: begin
                e.ex.alumux2_sel = alumux2_s_imm;
                e.mem.marmux_sel = marmux_alu_out;
                e.mem.dmem_write = 1'b1;
            end
            op_imm, op_reg: begin
                e.wb.load_regfile = 1'b1;
                if (w[6:0] == op_reg) e.ex.alumux2_sel = alumux2_rs2_out;
                e.ex.aluop = alu_ops'(f3);
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    e.ex.aluop = alu_add;      // slt family uses the comparator.
                    e.ex.cmpop = (f3 == 3'd2) ? blt : bltu;
                    e.ex.cmpmux_sel = (w[6:0] == op_imm) ? cmpmux_i_imm : cmpmux_rs2_out;
                    e.wb.regfilemux_sel = regfilemux_br_en;
                end
                if (f3 == 3'd5) e.ex.aluop = b5 ? alu_sra : alu_srl;
                if (f3 == 3'd0 && w[6:0] == op_reg && b5) e.ex.aluop = alu_sub;
            end
            default: begin
            end
        endcase
        return e;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp == act) else begin
            $display("Fail %s %s expected %0h actual %0h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            vld = '0;
        end
        else begin
            exp_stall = vld[0] && shadow[0].mem.dmem_read && (shadow[0].wb.rd != 5'd0) &&
                        ((reads_rs1(instr[6:0]) && instr[19:15] == shadow[0].wb.rd) ||
                         (reads_rs2(instr[6:0]) && instr[24:20] == shadow[0].wb.rd));
            check("ex_valid", 32'(vld[0]), 32'(ex_valid));
            check("mem_valid", 32'(vld[1]), 32'(mem_valid));
            check("wb_valid", 32'(vld[2]), 32'(wb_valid));
            check("stall", 32'(exp_stall), 32'(stall));
            check("imem_read", 32'(!exp_stall), 32'(imem_read));
            if (vld[0]) begin
                check("ex word", 32'(shadow[0].ex), 32'(ctrlex));
            end
            check("dmem_read", 32'(vld[1] && shadow[1].mem.dmem_read), 32'(dmem_read));
            check("dmem_write", 32'(vld[1] && shadow[1].mem.dmem_write), 32'(dmem_write));
            if (vld[1]) begin
                check("mem word", 32'(shadow[1].mem), 32'(ctrlmem));
            end
            if (vld[2]) begin
                check("load_regfile", 32'(shadow[2].wb.load_regfile), 32'(ctrlwb.load_regfile));
                check("regfilemux", 32'(shadow[2].wb.regfilemux_sel),
                      32'(ctrlwb.regfilemux_sel));
                check("rd", 32'(shadow[2].wb.rd), 32'(ctrlwb.rd));
                check("wb word", 32'(shadow[2].wb), 32'(ctrlwb));
            end
            // Inputs stay put until the next edge, so advance the model now.
            shadow[2] = shadow[1];
            shadow[1] = shadow[0];
            shadow[0] = model_decode(instr);
            vld = {vld[1], vld[0], instr_valid && !exp_stall && !branch_taken};
        end
    end

    // ########################################
    // Sequencing
    // ########################################

    // Called 2 ns after an edge, returns 2 ns after the edge that took the word.
    task automatic issue(input logic [31:0] w, input logic br);
        int guard;
        instr = w;
        instr_valid = 1'b1;
        branch_taken = br;
        guard = 0;
        @(negedge clk);
        while (stall && guard < 8) begin
            @(posedge clk);
            #2 branch_taken = 1'b0;            // Hold the word through the stall.
            @(negedge clk);
            guard++;
        end
        if (guard >= 8) begin
            $display("Timeout: stall did not clear in %s", cur_test);
            errors++;
        end
        @(posedge clk);
        #2 branch_taken = 1'b0;
        instr_valid = 1'b0;
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        instr_valid = 1'b0;
        while ((ex_valid || mem_valid || wb_valid) && guard < 20) begin
            @(posedge clk);
            #2 guard++;
        end
        if (guard >= 20) begin
            $display("Timeout: pipeline did not drain in %s", cur_test);
            errors++;
        end
    endtask

    task automatic finish_test();
        tests++;
        $display("test %s done, errors so far %0d", cur_test, errors);
    endtask

    initial begin
        logic [3:0] pick;
        rv32i_opcode op;
        reset = 1'b1;
        instr = '0;
        instr_valid = 1'b0;
        branch_taken = 1'b0;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        @(negedge clk);
        check("dmem_read", 32'd0, 32'(dmem_read));
        check("dmem_write", 32'd0, 32'(dmem_write));
        check("imem_read", 32'd1, 32'(imem_read));
        @(posedge clk);
        #2 finish_test();

        cur_test = "random_stream";
        for (int n = 0; n < 300; n++) begin
            pick = 4'(rand_bits(4));
            case (pick)
                4'd0: op = op_lui;
                4'd1: op = op_auipc;
                4'd2: op = op_jal;
                4'd3: op = op_jalr;
                4'd4: op = op_br;
                4'd5, 4'd9, 4'd10: op = op_load;
                4'd6, 4'd11: op = op_store;
                4'd7, 4'd12, 4'd13: op = op_imm;
                default: op = op_reg;
            endcase
            issue(encode(op, 3'(rand_bits(3)), rand_bits(1) == 8'd1, 5'(rand_bits(3)),
                         5'(rand_bits(3)), 5'(rand_bits(3))), rand_bits(3) == 8'd0);
        end
        drain();
        finish_test();

        cur_test = "load_use";
        issue(encode(op_load, 3'd2, 1'b0, 5'd5, 5'd1, 5'd0), 1'b0);
        issue(encode(op_reg, 3'd0, 1'b1, 5'd6, 5'd2, 5'd5), 1'b0);
        issue(encode(op_load, 3'd0, 1'b0, 5'd0, 5'd1, 5'd0), 1'b0);
        issue(encode(op_store, 3'd2, 1'b0, 5'd0, 5'd0, 5'd0), 1'b0);
        issue(encode(op_load, 3'd4, 1'b0, 5'd7, 5'd1, 5'd0), 1'b0);
        issue(encode(op_lui, 3'd7, 1'b0, 5'd3, 5'd7, 5'd7), 1'b0);
        issue(encode(op_load, 3'd1, 1'b0, 5'd3, 5'd1, 5'd0), 1'b0);
        issue(encode(op_imm, 3'd0, 1'b0, 5'd2, 5'd4, 5'd3), 1'b0);
        drain();
        finish_test();

        cur_test = "branch_squash";
        issue(encode(op_br, 3'd1, 1'b0, 5'd0, 5'd1, 5'd2), 1'b0);
        issue(encode(op_imm, 3'd5, 1'b1, 5'd4, 5'd2, 5'd0), 1'b1);
        issue(encode(op_jal, 3'd0, 1'b0, 5'd1, 5'd0, 5'd0), 1'b0);
        drain();
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #2_000_000;
        $display("Timeout: simulation did not finish");
        $display("=== FAIL ===");
        $finish;
    end

endmodule : ctrl_pipeline_tb

// File: dv/ctrl_pipeline_checker.sv
`timescale 1ns/1ns

module ctrl_pipeline_checker
    import rv32i_types::*;
    import ctrl_types::*;
(
    input logic         clk,
    input logic         reset,
    input logic         stall,
    input logic         branch_taken,
    input logic         ex_valid,
    input logic         mem_valid,
    input logic         wb_valid,
    input logic         dmem_read,
    input logic         dmem_write,
    input ctrlmem_reg_t ctrlmem,
    input rv32i_opcode  opcode,
    input logic [4:0]   rs1,
    input logic [4:0]   ex_rd
);

    // ########################################
    // Stall and flush
    // ########################################

    stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
        stall |=> !stall && !ex_valid)
        else $error("stall lasted more than one cycle or EX took the word");

    stall_needs_rd: assert property (@(posedge clk) disable iff (reset)
        stall |-> ex_rd != 5'd0)
        else $error("stall raised on x0");

    no_sources: assert property (@(posedge clk) disable iff (reset)
        opcode inside {op_lui, op_auipc, op_jal} |-> !stall)
        else $error("stall raised for an instruction without sources");

    rs1_only: assert property (@(posedge clk) disable iff (reset)
        (opcode inside {op_jalr, op_load, op_imm} && rs1 != ex_rd) |-> !stall)
        else $error("stall raised on the unused rs2 field");

    branch_flush: assert property (@(posedge clk) disable iff (reset)
        branch_taken |=> !ex_valid)
        else $error("branch did not squash the entry entering EX");

    reset_clear: assert property (@(posedge clk)
        reset |=> !ex_valid && !mem_valid && !wb_valid)
        else $error("valid bits set after reset");

    // ########################################
    // Memory strobes
    // ########################################

    one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(dmem_read && dmem_write))
        else $error("read and write strobes together");

    mar_source: assert property (@(posedge clk) disable iff (reset)
        (dmem_read || dmem_write) |-> ctrlmem.marmux_sel == marmux_alu_out)
        else $error("memory address not taken from the ALU");

endmodule : ctrl_pipeline_checker

bind ctrl_pipeline ctrl_pipeline_checker i_checker (
    .clk(clk), .reset(reset), .stall(stall), .branch_taken(branch_taken),
    .ex_valid(ex_valid), .mem_valid(mem_valid), .wb_valid(wb_valid),
    .dmem_read(dmem_read), .dmem_write(dmem_write), .ctrlmem(ctrlmem),
    .opcode(opcode), .rs1(rs1), .ex_rd(ex_q.wb.rd)
);

// File: hw/ctrl_pipeline.sv
`timescale 1ns/1ns

module ctrl_pipeline
    import rv32i_types::*;
    import ctrl_types::*;
(
    input  logic            clk,
    input  logic            reset,

    input  logic [xlen-1:0] instr,
    input  logic            instr_valid,
    input  logic            branch_taken,

    output logic            stall,
    output logic            imem_read,

    output logic            ex_valid,
    output ctrlex_reg_t     ctrlex,

    output logic            mem_valid,
    output ctrlmem_reg_t    ctrlmem,
    output logic            dmem_read,
    output logic            dmem_write,

    output logic            wb_valid,
    output ctrlwb_reg_t     ctrlwb
);

    rv32i_opcode      opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [reg_w-1:0] rd;
    logic [reg_w-1:0] rs1;
    logic [reg_w-1:0] rs2;

    ctrlex_reg_t  dec_ex;
    ctrlmem_reg_t dec_mem;
    ctrlwb_reg_t  dec_wb;
    ex_stage_t    id_ex;
    ex_stage_t    ex_q;
    mem_stage_t   ex_mem;
    mem_stage_t   mem_q;
    logic         bubble;

    // ######################################
    // Decode
    // ######################################

    assign opcode = rv32i_opcode'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    ctrl_word i_ctrl_word (
        .opcode  (opcode),
        .funct3  (funct3),
        .funct7  (funct7),
        .rd_in   (rd),
        .rs1_in  (rs1),
        .rs2_in  (rs2),
        .ctrlex  (dec_ex),
        .ctrlmem (dec_mem),
        .ctrlwb  (dec_wb)
    );

    assign id_ex = '{ex: dec_ex, mem: dec_mem, wb: dec_wb};

    hazard_unit i_hazard_unit (
        .opcode       (opcode),
        .rs1          (rs1),
        .rs2          (rs2),
        .ex_valid     (ex_valid),
        .ex_load      (ex_q.mem.dmem_read),
        .ex_rd        (ex_q.wb.rd),
        .branch_taken (branch_taken),
        .stall        (stall),
        .bubble       (bubble)
    );

    assign imem_read = ~stall;                 // Fetch holds while stalled.

    // ######################################
    // Stage registers
    // ######################################

    stage_reg #(.payload_t(ex_stage_t)) i_ex_reg (
        .clk(clk), .reset(reset), .hold(1'b0), .flush(bubble),
        .valid_in(instr_valid), .data_in(id_ex), .valid(ex_valid), .data(ex_q)
    );

    assign ctrlex = ex_q.ex;
    assign ex_mem = '{mem: ex_q.mem, wb: ex_q.wb};

    stage_reg #(.payload_t(mem_stage_t)) i_mem_reg (
        .clk(clk), .reset(reset), .hold(1'b0), .flush(1'b0),
        .valid_in(ex_valid), .data_in(ex_mem), .valid(mem_valid), .data(mem_q)
    );

    assign ctrlmem = mem_q.mem;
    assign dmem_read = mem_valid && mem_q.mem.dmem_read;     // No access for bubbles.
    assign dmem_write = mem_valid && mem_q.mem.dmem_write;

    stage_reg #(.payload_t(ctrlwb_reg_t)) i_wb_reg (
        .clk(clk), .reset(reset), .hold(1'b0), .flush(1'b0),
        .valid_in(mem_valid), .data_in(mem_q.wb), .valid(wb_valid), .data(ctrlwb)
    );

endmodule : ctrl_pipeline

// File: hw/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit
    import rv32i_types::*;
(
    input  rv32i_opcode      opcode,           // Decode instruction.
    input  logic [reg_w-1:0] rs1,
    input  logic [reg_w-1:0] rs2,

    input  logic             ex_valid,
    input  logic             ex_load,
    input  logic [reg_w-1:0] ex_rd,

    input  logic             branch_taken,

    output logic             stall,
    output logic             bubble
);

    logic uses_rs1;
    logic uses_rs2;
    logic load_in_ex;
    logic rs1_hit;
    logic rs2_hit;

    // Which source fields the decode instruction really reads.
    always_comb begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            op_jalr, op_load, op_imm: begin
                uses_rs1 = 1'b1;
            end
            op_br, op_store, op_reg: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            default: begin
                // lui, auipc and jal have no sources.
            end
        endcase
    end

    // x0 never carries a dependency.
    assign load_in_ex = ex_valid && ex_load && (ex_rd != zero_reg);

    assign rs1_hit = uses_rs1 && (rs1 == ex_rd);
    assign rs2_hit = uses_rs2 && (rs2 == ex_rd);

    assign stall = load_in_ex && (rs1_hit || rs2_hit);
    assign bubble = stall || branch_taken;     // Kills the entry entering EX.

endmodule : hazard_unit

// File: hw/stage_reg.sv
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  logic     flush,
    input  logic     valid_in,
    input  payload_t data_in,

    output logic     valid,
    output payload_t data
);

    // ######################################
    // Valid tag
    // ######################################

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;                     // Bubble.
        end
        else if (!hold) begin
            valid <= valid_in;
        end
    end

    // ######################################
    // Payload
    // ######################################

    // Loaded even for bubbles, valid alone tells them apart.
    always_ff @(posedge clk) begin
        if (!hold) begin
            data <= data_in;
        end
    end

endmodule : stage_reg

// File: hw/ctrl_word.sv
`timescale 1ns/1ns

module ctrl_word
    import rv32i_types::*;
    import ctrl_types::*;
(
    input  rv32i_opcode      opcode,
    input  logic [2:0]       funct3,
    input  logic [6:0]       funct7,
    input  logic [reg_w-1:0] rd_in,
    input  logic [reg_w-1:0] rs1_in,
    input  logic [reg_w-1:0] rs2_in,

    output ctrlex_reg_t      ctrlex,
    output ctrlmem_reg_t     ctrlmem,
    output ctrlwb_reg_t      ctrlwb
);

    arith_funct3_t arith_f3;
    load_funct3_t  load_f3;

    assign arith_f3 = arith_funct3_t'(funct3);
    assign load_f3 = load_funct3_t'(funct3);

    always_comb begin
        // Defaults.
        ctrlex.pcmux_sel   = pcmux_pc_plus4;
        ctrlex.alumux1_sel = alumux1_rs1_out;
        ctrlex.alumux2_sel = alumux2_i_imm;
        ctrlex.aluop       = alu_add;
        ctrlex.cmpmux_sel  = cmpmux_rs2_out;
        ctrlex.cmpop       = branch_funct3_t'(funct3);
        ctrlex.is_branch   = 1'b0;

        ctrlmem.marmux_sel = marmux_pc_out;
        ctrlmem.dmem_read  = 1'b0;
        ctrlmem.dmem_write = 1'b0;
        ctrlmem.funct3     = funct3;

        ctrlwb.load_regfile   = 1'b0;
        ctrlwb.regfilemux_sel = regfilemux_alu_out;
        ctrlwb.rd             = rd_in;
        ctrlwb.rs1            = rs1_in;
        ctrlwb.rs2            = rs2_in;

        case (opcode)
            op_lui: begin
                ctrlwb.load_regfile   = 1'b1;
                ctrlwb.regfilemux_sel = regfilemux_u_imm;
            end

            op_auipc: begin
                ctrlex.alumux1_sel  = alumux1_pc_out;
                ctrlex.alumux2_sel  = alumux2_u_imm;
                ctrlwb.load_regfile = 1'b1;
            end

            op_jal: begin
                ctrlex.pcmux_sel      = pcmux_alu_out;
                ctrlex.alumux1_sel    = alumux1_pc_out;
                ctrlex.alumux2_sel    = alumux2_j_imm;
                ctrlwb.load_regfile   = 1'b1;
                ctrlwb.regfilemux_sel = regfilemux_pc_plus4;
            end

            op_jalr: begin
                ctrlex.pcmux_sel      = pcmux_alu_mod2;   // rs1 + i_imm.
                ctrlwb.load_regfile   = 1'b1;
                ctrlwb.regfilemux_sel = regfilemux_pc_plus4;
            end

            op_br: begin
                ctrlex.alumux1_sel = alumux1_pc_out;      // Target is pc + b_imm.
                ctrlex.alumux2_sel = alumux2_b_imm;
                ctrlex.is_branch   = 1'b1;
            end

            op_load: begin
                ctrlmem.marmux_sel = marmux_alu_out;
                ctrlmem.dmem_read  = 1'b1;
                ctrlwb.load_regfile = 1'b1;
                case (load_f3)
                    lb:      ctrlwb.regfilemux_sel = regfilemux_lb;
                    lbu:     ctrlwb.regfilemux_sel = regfilemux_lbu;
                    lh:      ctrlwb.regfilemux_sel = regfilemux_lh;
                    lhu:     ctrlwb.regfilemux_sel = regfilemux_lhu;
                    lw:      ctrlwb.regfilemux_sel = regfilemux_lw;
                    default: ctrlwb.load_regfile = 1'b0;  // Reserved width.
                endcase
            end

            op_store: begin
                ctrlex.alumux2_sel = alumux2_s_imm;
                ctrlmem.marmux_sel = marmux_alu_out;
                ctrlmem.dmem_write = 1'b1;
            end

            op_imm: begin
                ctrlwb.load_regfile = 1'b1;
                case (arith_f3)
                    slt: begin
                        ctrlwb.regfilemux_sel = regfilemux_br_en;
                        ctrlex.cmpmux_sel     = cmpmux_i_imm;
                        ctrlex.cmpop          = blt;
                    end
                    sltu: begin
                        ctrlwb.regfilemux_sel = regfilemux_br_en;
                        ctrlex.cmpmux_sel     = cmpmux_i_imm;
                        ctrlex.cmpop          = bltu;
                    end
                    sr: begin
                        ctrlex.aluop = funct7[5] ? alu_sra : alu_srl;
                    end
                    default: begin
                        ctrlex.aluop = alu_ops'(funct3);  // addi has no sub form.
                    end
                endcase
            end

            op_reg: begin
                ctrlwb.load_regfile = 1'b1;
                ctrlex.alumux2_sel  = alumux2_rs2_out;
                case (arith_f3)
                    add: begin
                        ctrlex.aluop = funct7[5] ? alu_sub : alu_add;
                    end
                    slt: begin
                        ctrlwb.regfilemux_sel = regfilemux_br_en;
                        ctrlex.cmpop          = blt;
                    end
                    sltu: begin
                        ctrlwb.regfilemux_sel = regfilemux_br_en;
                        ctrlex.cmpop          = bltu;
                    end
                    sr: begin
                        ctrlex.aluop = funct7[5] ? alu_sra : alu_srl;
                    end
                    default: begin
                        ctrlex.aluop = alu_ops'(funct3);
                    end
                endcase
            end

            default: begin
                // Unknown opcode keeps the defaults and writes nothing.
            end
        endcase
    end

endmodule : ctrl_word

// File: hw/ctrl_types.sv
package ctrl_types;
    import rv32i_types::*;

    // ######################################
    // Select widths
    // ######################################

    localparam int pcmux_w = 2;
    localparam int alumux2_w = 3;
    localparam int regfilemux_w = 4;

    // ######################################
    // Datapath mux selects
    // ######################################

    typedef enum logic [pcmux_w-1:0] {
        pcmux_pc_plus4 = 2'b00,
        pcmux_alu_out  = 2'b01,
        pcmux_alu_mod2 = 2'b10                 // Target with bit 0 cleared.
    } pcmux_sel_t;

    typedef enum logic {
        alumux1_rs1_out = 1'b0,
        alumux1_pc_out  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [alumux2_w-1:0] {
        alumux2_i_imm   = 3'd0,
        alumux2_u_imm   = 3'd1,
        alumux2_b_imm   = 3'd2,
        alumux2_s_imm   = 3'd3,
        alumux2_j_imm   = 3'd4,
        alumux2_rs2_out = 3'd5
    } alumux2_sel_t;

    typedef enum logic {
        cmpmux_rs2_out = 1'b0,
        cmpmux_i_imm   = 1'b1
    } cmpmux_sel_t;

    typedef enum logic {
        marmux_pc_out  = 1'b0,
        marmux_alu_out = 1'b1
    } marmux_sel_t;

    typedef enum logic [regfilemux_w-1:0] {
        regfilemux_alu_out  = 4'd0,
        regfilemux_br_en    = 4'd1,            // Comparator result, for slt.
        regfilemux_u_imm    = 4'd2,
        regfilemux_lw       = 4'd3,
        regfilemux_pc_plus4 = 4'd4,
        regfilemux_lb       = 4'd5,
        regfilemux_lbu      = 4'd6,
        regfilemux_lh       = 4'd7,
        regfilemux_lhu      = 4'd8
    } regfilemux_sel_t;

    // ######################################
    // Per-stage control words
    // ######################################

    typedef struct packed {
        pcmux_sel_t     pcmux_sel;
        alumux1_sel_t   alumux1_sel;
        alumux2_sel_t   alumux2_sel;
        alu_ops         aluop;
        cmpmux_sel_t    cmpmux_sel;
        branch_funct3_t cmpop;
        logic           is_branch;
    } ctrlex_reg_t;

    typedef struct packed {
        marmux_sel_t marmux_sel;
        logic        dmem_read;
        logic        dmem_write;
        logic [2:0]  funct3;                   // Access width for the memory unit.
    } ctrlmem_reg_t;

    typedef struct packed {
        logic             load_regfile;
        regfilemux_sel_t  regfilemux_sel;
        logic [reg_w-1:0] rd;
        logic [reg_w-1:0] rs1;
        logic [reg_w-1:0] rs2;
    } ctrlwb_reg_t;

    // Payloads of the ID/EX and EX/MEM registers.
    typedef struct packed {
        ctrlex_reg_t  ex;
        ctrlmem_reg_t mem;
        ctrlwb_reg_t  wb;
    } ex_stage_t;

    typedef struct packed {
        ctrlmem_reg_t mem;
        ctrlwb_reg_t  wb;
    } mem_stage_t;

endpackage : ctrl_types

// File: hw/rv32i_types.sv
package rv32i_types;

    // ######################################
    // Widths and fixed register numbers
    // ######################################

    localparam int xlen = 32;                  // Instruction word width.
    localparam int reg_w = 5;                  // Register number width.
    localparam logic [reg_w-1:0] zero_reg = 5'd0;

    // ######################################
    // Major opcodes
    // ######################################

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,                 // Register-immediate arithmetic.
        op_reg   = 7'b0110011                  // Register-register arithmetic.
    } rv32i_opcode;

    // ######################################
    // funct3 encodings
    // ######################################

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add  = 3'b000,                         // Also sub, picked by funct7.
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,                         // srl or sra, picked by funct7.
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    // ALU op shares funct3 codes, sra and sub sit in the slt slots.
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

endpackage : rv32i_types
